// ==== vlog.f ====
verilog/adder_pkg.sv
verilog/pipe_delay.sv
verilog/pgk_encode.sv
verilog/prefix_stage.sv
verilog/prefix_adder.sv
verilog/carry_select_adder.sv
verif/tb_carry_select_adder.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_carry_select_adder: vlog.f $(SOURCES)
	verilator --binary --timing -f vlog.f --top-module tb_carry_select_adder \
		-o Vtb_carry_select_adder

run: obj_dir/Vtb_carry_select_adder
	./obj_dir/Vtb_carry_select_adder | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_carry_select_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_carry_select_adder;

    localparam int WIDTH   = 64;
    localparam int LATENCY = adder_pkg::adder_latency(WIDTH / 2);
    localparam int N_DIR   = 5;
    localparam int N_BND   = 6;
    localparam int N_B2B   = 9;
    localparam int N_RND   = 200;
    localparam int N       = N_DIR + N_BND + N_B2B + N_RND;
    localparam int TIMEOUT = 2 * N + LATENCY + 20;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             in_valid;
    logic             cin;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             out_valid;
    logic             cout;
    logic [WIDTH-1:0] sum;

    // stimulus and expected results with one row per cycle
    logic             row_valid [0:N-1];
    logic [WIDTH-1:0] row_a     [0:N-1];
    logic [WIDTH-1:0] row_b     [0:N-1];
    logic             row_cin   [0:N-1];
    logic [WIDTH-1:0] row_sum   [0:N-1];
    logic             row_cout  [0:N-1];

    int    grp_first [0:4];
    string grp_name  [0:3];

    // rows in flight and the cycle each one is due
    int pending [$];
    int due_q   [$];

    int     cycle;
    int     checks;
    int     errors;
    integer seed;

    carry_select_adder #(
        .WIDTH (WIDTH)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .cin       (cin),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .cout      (cout),
        .sum       (sum)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [WIDTH-1:0] got,
                         input logic [WIDTH-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic put_row(input int idx, input logic valid, input logic [WIDTH-1:0] op_a,
                           input logic [WIDTH-1:0] op_b, input logic c,
                           input logic [WIDTH-1:0] exp_sum, input logic exp_cout);
        row_valid[idx] = valid;
        row_a[idx]     = op_a;
        row_b[idx]     = op_b;
        row_cin[idx]   = c;
        row_sum[idx]   = exp_sum;
        row_cout[idx]  = exp_cout;
    endtask

    // expected value from {cout, sum} = a + b + cin
    task automatic put_rule_row(input int idx, input logic valid, input logic [WIDTH-1:0] op_a,
                                input logic [WIDTH-1:0] op_b, input logic c);
        logic [WIDTH:0] full;
        full = {1'b0, op_a} + {1'b0, op_b} + {{WIDTH{1'b0}}, c};
        put_row(idx, valid, op_a, op_b, c, full[WIDTH-1:0], full[WIDTH]);
    endtask

    task automatic load_table();
        int          r;
        logic [31:0] rnd;
        logic        b2b_valid [0:N_B2B-1];
        b2b_valid = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
        r = 0;
        put_row(r++, 1'b1, 64'h0, 64'h0, 1'b0, 64'h0, 1'b0);
        put_row(r++, 1'b1, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b0, 64'h0, 1'b1);
        put_row(r++, 1'b1, 64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 1'b0,
                64'hffff_ffff_ffff_ffff, 1'b0);
        put_row(r++, 1'b1, 64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaaa, 1'b1,
                64'h0, 1'b1);
        put_row(r++, 1'b1, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b1,
                64'hffff_ffff_ffff_ffff, 1'b1);
        // low half carry out with and without cin
        put_row(r++, 1'b1, 64'h0000_0000_ffff_ffff, 64'h1, 1'b0, 64'h0000_0001_0000_0000, 1'b0);
        put_row(r++, 1'b1, 64'h0000_0000_ffff_fffe, 64'h1, 1'b0, 64'h0000_0000_ffff_ffff, 1'b0);
        put_row(r++, 1'b1, 64'h0000_0000_ffff_ffff, 64'h0, 1'b1, 64'h0000_0001_0000_0000, 1'b0);
        put_row(r++, 1'b1, 64'h0000_0000_ffff_fffe, 64'h0, 1'b1, 64'h0000_0000_ffff_ffff, 1'b0);
        put_row(r++, 1'b1, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 64'h0, 1'b1);
        put_row(r++, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0001_8000_0000, 1'b0,
                64'h1234_567a_0000_0000, 1'b0);
        for (int i = 0; i < N_B2B; i++)
        begin
            rnd = $random(seed);
            put_rule_row(r++, b2b_valid[i], {$random(seed), $random(seed)},
                         {$random(seed), $random(seed)}, rnd[0]);
        end
        for (int i = 0; i < N_RND; i++)
        begin
            rnd = $random(seed);
            put_rule_row(r++, 1'b1, {$random(seed), $random(seed)},
                         {$random(seed), $random(seed)}, rnd[0]);
        end
        grp_first = '{0, N_DIR, N_DIR + N_BND, N_DIR + N_BND + N_B2B, N};
        grp_name  = '{"directed", "carry_select", "back_to_back", "random"};
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin : b_monitor
        logic exp_valid;
        int   idx;
        exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
        check("out_valid", WIDTH'(out_valid), WIDTH'(exp_valid));
        if (exp_valid)
        begin
            idx = pending.pop_front();
            void'(due_q.pop_front());
            check("sum", sum, row_sum[idx]);
            check("cout", WIDTH'(cout), WIDTH'(row_cout[idx]));
        end
    end

    initial
    begin
        int chk_start;
        int err_start;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        cin      = 1'b0;
        a        = '0;
        b        = '0;
        cycle    = 0;
        checks   = 0;
        errors   = 0;
        seed     = 32'h4d67ab6b;
        load_table();

        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        repeat (3) @(posedge clk);
        $display("test %-12s checks %0d errors %0d", "reset", checks, errors);

        for (int g = 0; g < 4; g++)
        begin
            chk_start = checks;
            err_start = errors;
            for (int i = grp_first[g]; i < grp_first[g+1]; i++)
            begin
                @(posedge clk);
                #5;
                in_valid = row_valid[i];
                a        = row_a[i];
                b        = row_b[i];
                cin      = row_cin[i];
                if (row_valid[i])
                begin
                    pending.push_back(i);
                    due_q.push_back(cycle + LATENCY);
                end
            end
            @(posedge clk);
            #5;
            in_valid = 1'b0;
            while (pending.size() > 0)
            begin
                @(posedge clk);
            end
            @(negedge clk);
            $display("test %-12s checks %0d errors %0d", grp_name[g],
                     checks - chk_start, errors - err_start);
        end

        $display("total checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/carry_select_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module carry_select_adder #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  logic             cin,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic             out_valid,
    output logic             cout,
    output logic [WIDTH-1:0] sum
);

    localparam int HALF    = WIDTH / 2;
    localparam int LATENCY = adder_pkg::adder_latency(HALF);

    logic [HALF-1:0] lo_sum_c0;
    logic [HALF-1:0] lo_sum_c1;
    logic            lo_cout_c0;
    logic            lo_cout_c1;
    logic [HALF-1:0] hi_sum_c0;
    logic [HALF-1:0] hi_sum_c1;
    logic            hi_cout_c0;
    logic            hi_cout_c1;
    logic            cin_d;
    logic            carry_mid;

    prefix_adder #(
        .WIDTH (HALF)
    ) i_lo (
        .clk     (clk),
        .arst_n  (arst_n),
        .a       (a[HALF-1:0]),
        .b       (b[HALF-1:0]),
        .sum_c0  (lo_sum_c0),
        .sum_c1  (lo_sum_c1),
        .cout_c0 (lo_cout_c0),
        .cout_c1 (lo_cout_c1)
    );

    prefix_adder #(
        .WIDTH (HALF)
    ) i_hi (
        .clk     (clk),
        .arst_n  (arst_n),
        .a       (a[WIDTH-1:HALF]),
        .b       (b[WIDTH-1:HALF]),
        .sum_c0  (hi_sum_c0),
        .sum_c1  (hi_sum_c1),
        .cout_c0 (hi_cout_c0),
        .cout_c1 (hi_cout_c1)
    );

    // carry in stays aligned with its operands
    pipe_delay #(
        .DEPTH (LATENCY),
        .T     (logic)
    ) i_cin_delay (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (cin),
        .q      (cin_d)
    );

    pipe_delay #(
        .DEPTH (LATENCY),
        .T     (logic)
    ) i_valid_delay (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (in_valid),
        .q      (out_valid)
    );

    // low half picks by cin, high half by the low carry out
    assign carry_mid        = cin_d ? lo_cout_c1 : lo_cout_c0;
    assign sum[HALF-1:0]    = cin_d ? lo_sum_c1 : lo_sum_c0;
    assign sum[WIDTH-1:HALF] = carry_mid ? hi_sum_c1 : hi_sum_c0;
    assign cout             = carry_mid ? hi_cout_c1 : hi_cout_c0;

endmodule

`default_nettype wire

// ==== verilog/prefix_adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_adder #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum_c0,
    output logic [WIDTH-1:0] sum_c1,
    output logic             cout_c0,
    output logic             cout_c1
);

    localparam int LATENCY      = adder_pkg::adder_latency(WIDTH);
    localparam int STAGES       = LATENCY - 1;
    localparam int LEVELS_TOTAL = $clog2(WIDTH);

    adder_pkg::pgk_t [WIDTH-1:0] stage_pgk [0:STAGES];
    adder_pkg::pgk_t [WIDTH-1:0] grp;

    logic [2*WIDTH-1:0] ops_d;
    logic [WIDTH-1:0]   a_d;
    logic [WIDTH-1:0]   b_d;
    logic [WIDTH-1:0]   carry_c0;
    logic [WIDTH-1:0]   carry_c1;

    pgk_encode #(
        .WIDTH (WIDTH)
    ) i_encode (
        .clk    (clk),
        .arst_n (arst_n),
        .a      (a),
        .b      (b),
        .pgk    (stage_pgk[0])
    );

    // spans 1,2 then 4,8 then 16 for a 32-bit half
    genvar s;
    for (s = 0; s < STAGES; s++)
    begin : g_stage
        localparam int SPAN   = 1 << (2 * s);
        localparam int REMAIN = LEVELS_TOTAL - 2 * s;

        prefix_stage #(
            .WIDTH  (WIDTH),
            .SPAN   (SPAN),
            .LEVELS ((REMAIN >= 2) ? 2 : 1)
        ) i_stage (
            .clk     (clk),
            .arst_n  (arst_n),
            .pgk_in  (stage_pgk[s]),
            .pgk_out (stage_pgk[s+1])
        );
    end

    assign grp = stage_pgk[STAGES];

    // operands wait for the tree
    pipe_delay #(
        .DEPTH (LATENCY),
        .T     (logic [2*WIDTH-1:0])
    ) i_ops_delay (
        .clk    (clk),
        .arst_n (arst_n),
        .d      ({a, b}),
        .q      (ops_d)
    );

    assign a_d = ops_d[2*WIDTH-1:WIDTH];
    assign b_d = ops_d[WIDTH-1:0];

    assign carry_c0[0] = 1'b0;
    assign carry_c1[0] = 1'b1;

    genvar i;
    for (i = 1; i < WIDTH; i++)
    begin : g_carry
        assign carry_c0[i] = grp[i-1][0];
        assign carry_c1[i] = grp[i-1][1];
    end

    assign sum_c0  = a_d ^ b_d ^ carry_c0;
    assign sum_c1  = a_d ^ b_d ^ carry_c1;
    assign cout_c0 = grp[WIDTH-1][0];
    assign cout_c1 = grp[WIDTH-1][1];

endmodule

`default_nettype wire

// ==== verilog/prefix_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module prefix_stage #(
    parameter int WIDTH  = 32,
    parameter int SPAN   = 1,
    parameter int LEVELS = 2
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  adder_pkg::pgk_t [WIDTH-1:0] pgk_in,
    output adder_pkg::pgk_t [WIDTH-1:0] pgk_out
);

    // lvl[0] is the stage input, lvl[LEVELS] goes to the register
    adder_pkg::pgk_t [WIDTH-1:0] lvl [0:LEVELS];

    assign lvl[0] = pgk_in;

    genvar l;
    genvar i;
    for (l = 0; l < LEVELS; l++)
    begin : g_level
        localparam int DIST = SPAN << l;

        for (i = 0; i < WIDTH; i++)
        begin : g_bit
            if (i >= DIST)
            begin : g_merge
                assign lvl[l+1][i] = adder_pkg::pgk_merge(lvl[l][i], lvl[l][i-DIST]);
            end
            else
            begin : g_pass
                // already a complete group down to bit 0
                assign lvl[l+1][i] = lvl[l][i];
            end
        end
    end

    pipe_delay #(
        .DEPTH (1),
        .T     (adder_pkg::pgk_t [WIDTH-1:0])
    ) i_stage_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .d      (lvl[LEVELS]),
        .q      (pgk_out)
    );

endmodule

`default_nettype wire

// ==== verilog/pgk_encode.sv ====
`timescale 1ns/1ns
`default_nettype none

module pgk_encode #(
    parameter int WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [WIDTH-1:0]            a,
    input  logic [WIDTH-1:0]            b,
    output adder_pkg::pgk_t [WIDTH-1:0] pgk
);

    adder_pkg::pgk_t [WIDTH-1:0] pgk_next;

    // bit 0 too, carry in is resolved after the tree
    always_comb
    begin
        for (int i = 0; i < WIDTH; i++)
        begin
            case ({a[i], b[i]})
                2'b00:
                begin
                    pgk_next[i] = adder_pkg::PGK_KILL;
                end
                2'b11:
                begin
                    pgk_next[i] = adder_pkg::PGK_GENERATE;
                end
                default:
                begin
                    pgk_next[i] = adder_pkg::PGK_PROPAGATE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pgk <= '0;
        end
        else
        begin
            pgk <= pgk_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_delay #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  T     d,
    output T     q
);

    // tap 0 is the input, tap DEPTH the oldest copy
    T taps [0:DEPTH];

    assign taps[0] = d;

    genvar i;
    for (i = 0; i < DEPTH; i++)
    begin : g_reg
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                taps[i+1] <= '0;
            end
            else
            begin
                taps[i+1] <= taps[i];
            end
        end
    end

    assign q = taps[DEPTH];

endmodule

`default_nettype wire

// ==== verilog/adder_pkg.sv ====
`default_nettype none

package adder_pkg;

    // upper bit: carry out for carry in 1, lower bit: carry out for carry in 0
    typedef logic [1:0] pgk_t;

    localparam pgk_t PGK_KILL      = 2'b00;
    localparam pgk_t PGK_PROPAGATE = 2'b10;
    localparam pgk_t PGK_GENERATE  = 2'b11;

    // hi sits above lo, result covers both spans
    function automatic pgk_t pgk_merge(input pgk_t hi, input pgk_t lo);
        pgk_t res;
        res[1] = hi[0] | (hi[1] & lo[1]);
        res[0] = hi[0] | (hi[1] & lo[0]);
        return res;
    endfunction

    // encode cycle plus one registered stage per two prefix levels
    function automatic int adder_latency(input int width);
        int levels;
        levels = $clog2(width);
        return 1 + (levels + 1) / 2;
    endfunction

endpackage

`default_nettype wire
